// ==== mem_stage_pkg.sv ====
// memory stage package: widths, field positions, word types, operation enum
`default_nettype none

package mem_stage_pkg;

    // ********************
    // widths
    // ********************
    localparam int XLEN   = 64;           // data path width
    localparam int STRB_W = XLEN / 8;     // byte lanes per word

    typedef logic [XLEN-1:0]   word_t;    // data or address
    typedef logic [31:0]       inst_t;    // raw instruction
    typedef logic [4:0]        reg_idx_t; // gpr index
    typedef logic [STRB_W-1:0] strb_t;    // byte write mask

    // ********************
    // instruction fields
    // ********************
    localparam int RD_LSB  = 7;           // rd at inst[11:7]
    localparam int RS2_LSB = 20;          // rs2 at inst[24:20]

    // link writes return pc of the next instruction
    localparam word_t LINK_STEP = word_t'(4);

    // ********************
    // stage operations
    // ********************
    // compact code from execute, replaces the wide one-hot opcode
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,  // bubble or no write-back
        OP_ALU  = 4'd1,  // write alu result
        OP_LINK = 4'd2,  // write pc + 4
        OP_CSR  = 4'd3,  // write csr value carried in src2
        OP_LB   = 4'd4,
        OP_LH   = 4'd5,
        OP_LW   = 4'd6,
        OP_LD   = 4'd7,
        OP_LBU  = 4'd8,
        OP_LHU  = 4'd9,
        OP_LWU  = 4'd10,
        OP_SB   = 4'd11,
        OP_SH   = 4'd12,
        OP_SW   = 4'd13,
        OP_SD   = 4'd14
    } mem_op_e;

endpackage

`default_nettype wire

// ==== mem_stage_reg.sv ====
// execute to memory pipeline register with stall hold and valid gating
`timescale 1ns/1ns
`default_nettype none

module mem_stage_reg (
    input  wire  logic                   clk,
    input  wire  logic                   rst,
    input  wire  logic                   ex_valid,
    input  wire  logic                   hold,          // writeback not ready
    input  wire  mem_stage_pkg::word_t   ex_pc,
    input  wire  mem_stage_pkg::word_t   ex_alu_result,
    input  wire  mem_stage_pkg::word_t   ex_src2,
    input  wire  mem_stage_pkg::inst_t   ex_inst,
    input  wire  mem_stage_pkg::mem_op_e ex_op,
    output logic                         valid,
    output mem_stage_pkg::word_t         pc,
    output mem_stage_pkg::word_t         alu_result,
    output mem_stage_pkg::word_t         src2,
    output mem_stage_pkg::inst_t         inst,
    output mem_stage_pkg::mem_op_e       op
);
    import mem_stage_pkg::*;

    logic    valid_q;
    mem_op_e op_q;
    word_t   pc_q;
    word_t   alu_q;
    word_t   src2_q;
    inst_t   inst_q;

    // ********************
    // control part
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
        end else if (!hold) begin
            valid_q <= ex_valid;      // invalid capture is a bubble
            op_q    <= ex_op;
        end
    end

    // payload, only meaningful with valid_q
    always_ff @(posedge clk) begin
        if (!hold) begin
            pc_q   <= ex_pc;
            alu_q  <= ex_alu_result;
            src2_q <= ex_src2;
            inst_q <= ex_inst;
        end
    end

    // single valid check of the stage, downstream sees clean zeros
    assign valid      = valid_q;
    assign op         = valid_q ? op_q : OP_NONE;
    assign pc         = valid_q ? pc_q : '0;
    assign alu_result = valid_q ? alu_q : '0;
    assign src2       = valid_q ? src2_q : '0;
    assign inst       = valid_q ? inst_q : '0;

    // stall must freeze the whole entry for the next cycle
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        hold |=> $stable({valid_q, op_q, pc_q, alu_q, src2_q, inst_q}));

endmodule

`default_nettype wire

// ==== store_path.sv ====
// store data forwarding from writeback, lane shift and byte mask
`timescale 1ns/1ns
`default_nettype none

module store_path (
    input  wire  mem_stage_pkg::mem_op_e  op,
    input  wire  mem_stage_pkg::word_t    addr,
    input  wire  mem_stage_pkg::word_t    src2,
    input  wire  mem_stage_pkg::word_t    fwd_wdata,
    input  wire  mem_stage_pkg::inst_t    inst,
    input  wire  logic                    fwd_valid,
    input  wire  logic                    fwd_wen,
    input  wire  mem_stage_pkg::reg_idx_t fwd_rd,
    output mem_stage_pkg::word_t          mem_wdata,
    output mem_stage_pkg::strb_t          mem_wmask
);
    import mem_stage_pkg::*;

    reg_idx_t rs2;
    logic     fwd_hit;
    word_t    st_data;     // store value after forwarding
    logic [2:0] off;       // byte offset in the word
    logic [5:0] bit_off;

    // ********************
    // forwarding
    // ********************
    assign rs2     = inst[RS2_LSB +: 5];
    assign fwd_hit = fwd_valid && fwd_wen && (fwd_rd == rs2);  // writeback still owns rs2
    assign st_data = fwd_hit ? fwd_wdata : src2;

    assign off     = addr[2:0];
    assign bit_off = {off, 3'b000};

    // ********************
    // lane placement
    // ********************
    always_comb begin
        mem_wdata = '0;
        mem_wmask = '0;
        case (op)
            OP_SB: begin
                mem_wdata = word_t'(st_data[7:0]) << bit_off;
                mem_wmask = strb_t'(1) << off;                // one-hot lane
            end
            OP_SH: begin
                if (off != 3'd7) begin                        // crossing the word is dropped
                    mem_wdata = word_t'(st_data[15:0]) << bit_off;
                    mem_wmask = strb_t'(2'b11) << off;
                end
            end
            OP_SW: begin
                if (addr[2]) begin
                    mem_wdata = {st_data[31:0], 32'b0};
                    mem_wmask = 8'hf0;
                end else begin
                    mem_wdata = {32'b0, st_data[31:0]};
                    mem_wmask = 8'h0f;
                end
            end
            OP_SD: begin
                mem_wdata = st_data;
                mem_wmask = '1;
            end
            default: ;                                        // no memory write
        endcase

        // loads and register ops never touch memory
        a_mask_store_only: assert (mem_wmask == '0 ||
            op inside {OP_SB, OP_SH, OP_SW, OP_SD});
    end

endmodule

`default_nettype wire

// ==== load_path.sv ====
// load lane extraction with sign or zero extension, read enable
`timescale 1ns/1ns
`default_nettype none

module load_path (
    input  wire  mem_stage_pkg::mem_op_e op,
    input  wire  mem_stage_pkg::word_t   addr,
    input  wire  mem_stage_pkg::word_t   mem_rdata,
    output mem_stage_pkg::word_t         load_data,
    output logic                         mem_ren
);
    import mem_stage_pkg::*;

    word_t       shifted;     // addressed byte moved to lane 0
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_word;

    // ********************
    // field select
    // ********************
    assign shifted = mem_rdata >> {addr[2:0], 3'b000};
    assign ld_byte = shifted[7:0];
    assign ld_half = (addr[2:0] != 3'd7) ? shifted[15:0] : 16'b0;  // offsets 0 to 6 only
    assign ld_word = addr[2] ? mem_rdata[63:32] : mem_rdata[31:0];

    assign mem_ren = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};

    // ********************
    // extension
    // ********************
    always_comb begin
        case (op)
            OP_LB:   load_data = {{56{ld_byte[7]}}, ld_byte};
            OP_LH:   load_data = {{48{ld_half[15]}}, ld_half};
            OP_LW:   load_data = {{32{ld_word[31]}}, ld_word};
            OP_LD:   load_data = mem_rdata;                     // whole word
            OP_LBU:  load_data = {56'b0, ld_byte};
            OP_LHU:  load_data = {48'b0, ld_half};
            OP_LWU:  load_data = {32'b0, ld_word};
            default: load_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== wb_select.sv ====
// register write enable decode and write-back value mux
`timescale 1ns/1ns
`default_nettype none

module wb_select (
    input  wire  mem_stage_pkg::mem_op_e op,
    input  wire  mem_stage_pkg::word_t   pc,
    input  wire  mem_stage_pkg::word_t   alu_result,
    input  wire  mem_stage_pkg::word_t   src2,
    input  wire  mem_stage_pkg::word_t   load_data,
    input  wire  mem_stage_pkg::inst_t   inst,
    output logic                         reg_wr_wen,
    output mem_stage_pkg::reg_idx_t      reg_wr_idx,
    output mem_stage_pkg::word_t         reg_wr_value
);
    import mem_stage_pkg::*;

    // ********************
    // source select
    // ********************
    always_comb begin
        reg_wr_wen   = 1'b1;
        reg_wr_value = '0;
        case (op)
            OP_ALU:  reg_wr_value = alu_result;
            OP_LINK: reg_wr_value = pc + LINK_STEP;  // jal, jalr return address
            OP_CSR:  reg_wr_value = src2;            // old csr value from execute
            OP_LB, OP_LH, OP_LW, OP_LD,
            OP_LBU, OP_LHU, OP_LWU:
                     reg_wr_value = load_data;
            default: reg_wr_wen   = 1'b0;            // stores and bubbles
        endcase

        // writeback relies on a clean zero when nothing is written
        a_value_needs_wen: assert (reg_wr_wen || reg_wr_value == '0);
    end

    assign reg_wr_idx = reg_wr_wen ? inst[RD_LSB +: 5] : '0;

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
// memory access stage top: register, store path, load path, write-back select
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire  logic                    clk,
    input  wire  logic                    rst,
    // from execute
    input  wire  logic                    ex_valid,
    output logic                          ex_ready,
    input  wire  mem_stage_pkg::word_t    ex_pc,
    input  wire  mem_stage_pkg::inst_t    ex_inst,
    input  wire  mem_stage_pkg::mem_op_e  ex_op,
    input  wire  mem_stage_pkg::word_t    ex_alu_result,
    input  wire  mem_stage_pkg::word_t    ex_src2,
    // to writeback
    output logic                          out_valid,
    input  wire  logic                    wb_ready,
    output mem_stage_pkg::word_t          out_pc,
    output mem_stage_pkg::inst_t          out_inst,
    output logic                          reg_wr_wen,
    output mem_stage_pkg::reg_idx_t       reg_wr_idx,
    output mem_stage_pkg::word_t          reg_wr_value,
    // writeback register, for store data forwarding
    input  wire  logic                    fwd_valid,
    input  wire  logic                    fwd_wen,
    input  wire  mem_stage_pkg::reg_idx_t fwd_rd,
    input  wire  mem_stage_pkg::word_t    fwd_wdata,
    // memory port, read data same cycle
    output mem_stage_pkg::word_t          mem_addr,
    output logic                          mem_ren,
    output mem_stage_pkg::word_t          mem_wdata,
    output mem_stage_pkg::strb_t          mem_wmask,
    input  wire  mem_stage_pkg::word_t    mem_rdata
);
    import mem_stage_pkg::*;

    logic    hold;
    mem_op_e op;
    word_t   alu_result;
    word_t   src2;
    word_t   load_data;

    // stage never blocks by itself
    assign ex_ready = wb_ready;
    assign hold     = ~wb_ready;
    assign mem_addr = alu_result;   // one address for load and store

    // ********************
    // stage register
    // ********************
    mem_stage_reg u_reg (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .hold(hold),
        .ex_pc(ex_pc), .ex_alu_result(ex_alu_result), .ex_src2(ex_src2),
        .ex_inst(ex_inst), .ex_op(ex_op),
        .valid(out_valid), .pc(out_pc), .alu_result(alu_result),
        .src2(src2), .inst(out_inst), .op(op)
    );

    // ********************
    // memory side
    // ********************
    store_path u_store (
        .op(op), .addr(alu_result), .src2(src2), .fwd_wdata(fwd_wdata),
        .inst(out_inst), .fwd_valid(fwd_valid), .fwd_wen(fwd_wen), .fwd_rd(fwd_rd),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask)
    );

    load_path u_load (
        .op(op), .addr(alu_result), .mem_rdata(mem_rdata),
        .load_data(load_data), .mem_ren(mem_ren)
    );

    // register file side
    wb_select u_wb (
        .op(op), .pc(out_pc), .alu_result(alu_result), .src2(src2),
        .load_data(load_data), .inst(out_inst),
        .reg_wr_wen(reg_wr_wen), .reg_wr_idx(reg_wr_idx), .reg_wr_value(reg_wr_value)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// testbench clock source, free running from time zero
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int HALF_NS = 2       // half period in ns
) (
    output logic clk
);

    initial clk = 1'b0;

    always #HALF_NS clk = ~clk;     // 4 ns period with the default

endmodule

`default_nettype wire

// ==== tb_mem_stage.sv ====
// memory stage testbench with stimulus, memory model, lfsr, reference functions and assertions
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage;
    import mem_stage_pkg::*;

    logic     clk, rst;
    logic     ex_valid, ex_ready, wb_ready, out_valid;
    logic     reg_wr_wen, mem_ren, fwd_valid, fwd_wen;
    mem_op_e  ex_op;
    word_t    ex_pc, ex_alu_result, ex_src2, out_pc, reg_wr_value, fwd_wdata;
    word_t    mem_addr, mem_wdata, mem_rdata;
    inst_t    ex_inst, out_inst;
    reg_idx_t reg_wr_idx, fwd_rd;
    strb_t    mem_wmask;

    logic [31:0] lfsr;
    word_t       mem_model [8];     // eight words indexed by addr[5:3]

    // entry captured one edge earlier
    logic    exp_valid;
    mem_op_e exp_op;
    word_t   exp_pc, exp_alu, exp_src2;
    inst_t   exp_inst;
    // gated view of that entry and the expected outputs
    mem_op_e  e_op;
    word_t    e_pc, e_alu, e_src2, ref_word, st_val, exp_wdata, exp_value;
    inst_t    e_inst;
    strb_t    exp_mask;
    logic     exp_wen, exp_ren;
    reg_idx_t exp_idx;

    tb_clock #(.HALF_NS(2)) clk_gen (.clk(clk));

    mem_stage dut0 (.*);

    // ********************
    // reference functions
    // ********************
    function automatic strb_t lane_mask(input mem_op_e op, input int o);
        strb_t m;
        m = '0;
        for (int i = 0; i < 8; i++) begin
            case (op)
                OP_SB:   m[i] = (i == o);
                OP_SH:   m[i] = (o != 7) && (i == o || i == o + 1);  // no word crossing
                OP_SW:   m[i] = (i / 4 == o / 4);                    // half picked by addr[2]
                OP_SD:   m[i] = 1'b1;
                default: m[i] = 1'b0;
            endcase
        end
        return m;
    endfunction

    function automatic word_t lane_data(input mem_op_e op, input int o, input word_t val);
        strb_t m;
        word_t d;
        int    base;                    // first lane of the stored value
        m    = lane_mask(op, o);
        d    = '0;
        base = (op == OP_SW) ? (o / 4) * 4 : (op == OP_SD) ? 0 : o;
        for (int i = 0; i < 8; i++)
            if (m[i])
                d[i*8 +: 8] = val[(i - base)*8 +: 8];
        return d;
    endfunction

    function automatic word_t extend_load(input mem_op_e op, input int o, input word_t w);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] x;
        b = 8'(w >> (8 * o));
        h = (o == 7) ? 16'h0 : 16'(w >> (8 * o));
        x = (o >= 4) ? w[63:32] : w[31:0];
        case (op)
            OP_LB:   return word_t'($signed(b));
            OP_LH:   return word_t'($signed(h));
            OP_LW:   return word_t'($signed(x));
            OP_LD:   return w;
            OP_LBU:  return word_t'(b);
            OP_LHU:  return word_t'(h);
            OP_LWU:  return word_t'(x);
            default: return '0;
        endcase
    endfunction

    function automatic word_t wb_value(input mem_op_e op, input word_t pc, input word_t alu,
                                       input word_t src2, input word_t ld);
        case (op)
            OP_ALU:  return alu;
            OP_LINK: return pc + 64'd4;             // return address
            OP_CSR:  return src2;
            OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU:
                     return ld;
            default: return '0;
        endcase
    endfunction

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    // ********************
    // memory model and entry record
    // ********************
    assign mem_rdata = mem_model[mem_addr[5:3]];   // same cycle read

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++)
                mem_model[i] <= 64'h9e3779b97f4a7c15 * word_t'(i + 1);
        end else begin
            for (int i = 0; i < STRB_W; i++)
                if (mem_wmask[i])
                    mem_model[mem_addr[5:3]][i*8 +: 8] <= mem_wdata[i*8 +: 8];
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_valid <= 1'b0;
        end else if (wb_ready) begin               // capture only when not stalled
            exp_valid <= ex_valid;
            exp_op    <= ex_op;
            exp_pc    <= ex_pc;
            exp_alu   <= ex_alu_result;
            exp_src2  <= ex_src2;
            exp_inst  <= ex_inst;
        end
    end

    assign e_op      = exp_valid ? exp_op : OP_NONE;
    assign e_pc      = exp_valid ? exp_pc : '0;
    assign e_alu     = exp_valid ? exp_alu : '0;
    assign e_src2    = exp_valid ? exp_src2 : '0;
    assign e_inst    = exp_valid ? exp_inst : '0;
    assign ref_word  = mem_model[e_alu[5:3]];
    assign st_val    = (fwd_valid && fwd_wen && fwd_rd == e_inst[24:20]) ? fwd_wdata : e_src2;
    assign exp_mask  = lane_mask(e_op, int'(e_alu[2:0]));
    assign exp_wdata = lane_data(e_op, int'(e_alu[2:0]), st_val);
    assign exp_value = wb_value(e_op, e_pc, e_alu, e_src2,
                                extend_load(e_op, int'(e_alu[2:0]), ref_word));
    assign exp_ren   = e_op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
    assign exp_wen   = exp_ren || e_op inside {OP_ALU, OP_LINK, OP_CSR};
    assign exp_idx   = exp_wen ? e_inst[11:7] : '0;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first failure");
    endtask

    // ********************
    // checks
    // ********************
    a_ready: assert property (@(posedge clk) ex_ready == wb_ready)
        else fail_run($sformatf("ERROR %0t ns: ex_ready %b with wb_ready %b", $time,
            $sampled(ex_ready), $sampled(wb_ready)));
    a_entry: assert property (@(posedge clk) disable iff (rst)
        out_valid == exp_valid && out_pc == e_pc && out_inst == e_inst && mem_addr == e_alu)
        else fail_run($sformatf("ERROR %0t ns: entry mismatch, valid %b pc %h addr %h",
            $time, $sampled(out_valid), $sampled(out_pc), $sampled(mem_addr)));
    a_store: assert property (@(posedge clk) disable iff (rst)
        mem_wmask == exp_mask && mem_wdata == exp_wdata)
        else fail_run($sformatf("ERROR %0t ns: store %h/%h, expected %h/%h", $time,
            $sampled(mem_wmask), $sampled(mem_wdata), $sampled(exp_mask), $sampled(exp_wdata)));
    a_ren: assert property (@(posedge clk) disable iff (rst) mem_ren == exp_ren)
        else fail_run($sformatf("ERROR %0t ns: mem_ren %b, expected %b", $time,
            $sampled(mem_ren), $sampled(exp_ren)));
    a_wb: assert property (@(posedge clk) disable iff (rst)
        reg_wr_wen == exp_wen && reg_wr_idx == exp_idx && reg_wr_value == exp_value)
        else fail_run($sformatf("ERROR %0t ns: write-back %b x%0d %h, expected %b x%0d %h",
            $time, $sampled(reg_wr_wen), $sampled(reg_wr_idx), $sampled(reg_wr_value),
            $sampled(exp_wen), $sampled(exp_idx), $sampled(exp_value)));
    a_stall: assert property (@(posedge clk) disable iff (rst)
        !wb_ready |=> $stable({out_valid, out_pc, out_inst, reg_wr_wen, reg_wr_idx,
            reg_wr_value, mem_addr, mem_ren, mem_wdata, mem_wmask}))
        else fail_run($sformatf("ERROR %0t ns: stage outputs changed during stall", $time));

    // ********************
    // stimulus
    // ********************
    task automatic drive_entry(input logic valid, input mem_op_e op, input word_t alu,
                               input logic with_fwd);
        if (with_fwd) begin                        // writeback holds still while stalled
            fwd_valid = 1'(rand_bits(1));
            fwd_wen   = 1'(rand_bits(1));
            fwd_rd    = rand_bits(1) != 0 ? ex_inst[24:20] : reg_idx_t'(rand_bits(5));
            fwd_wdata = rand_bits(64);
        end
        ex_valid      = valid;
        ex_op         = op;
        ex_alu_result = alu;
        ex_pc         = rand_bits(64);
        ex_src2       = rand_bits(64);
        ex_inst       = inst_t'(rand_bits(32));
    endtask

    task automatic wait_accept;
        int   n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = ex_ready;                      // ready level at this edge
            #1;
            n++;
            if (!taken && n > 16)
                fail_run("timeout: the stage accepted no entry within 16 cycles");
        end
    endtask

    task automatic send(input logic valid, input mem_op_e op, input word_t alu);
        drive_entry(valid, op, alu, 1'b1);
        wait_accept();
    endtask

    task automatic stall(input int cycles);
        wb_ready = 1'b0;
        drive_entry(1'b1, mem_op_e'(4'(rand_bits(4) % 15)), rand_bits(64), 1'b0);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        wb_ready = 1'b1;                           // this entry goes in at the next edge
        wait_accept();
    endtask

    initial begin
        word_t addr;
        lfsr          = 32'hda34586a;
        rst           = 1'b1;
        ex_valid      = 1'b0;
        ex_op         = OP_NONE;
        ex_pc         = '0;
        ex_inst       = '0;
        ex_alu_result = '0;
        ex_src2       = '0;
        wb_ready      = 1'b1;
        fwd_valid     = 1'b0;
        fwd_wen       = 1'b0;
        fwd_rd        = '0;
        fwd_wdata     = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (3) send(1'b0, OP_NONE, rand_bits(64));   // bubbles after reset

        // every store size at every offset with a whole word read back
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 8; k++) begin
                addr = (rand_bits(64) & ~64'h7) | word_t'(k);
                send(1'b1, mem_op_e'(4'(int'(OP_SB) + s)), addr);
                send(1'b1, OP_LD, addr);
            end
        end

        // random mix with bubbles and stalls
        repeat (400) begin
            if (rand_bits(3) == 0)
                stall(2 + int'(rand_bits(2)));
            else
                send(rand_bits(3) != 0, mem_op_e'(4'(rand_bits(4) % 15)), rand_bits(64));
        end

        repeat (2) @(posedge clk);                 // last entry gets checked
        #1;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage.f ====
mem_stage_pkg.sv
mem_stage_reg.sv
store_path.sv
load_path.sv
wb_select.sv
mem_stage.sv
tb_clock.sv
tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_mem_stage -f mem_stage.f -o sim_mem_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_mem_stage
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
